// ==== include/csa_settings.svh ====
`ifndef CSA_SETTINGS_SVH
`define CSA_SETTINGS_SVH

// register bus
`define CSA_DATA_WIDTH 32
`define CSA_ADDR_BITS 5

`define CSA_UNIT_NUM 5
`define CSA_IN_BYTES 5
`define CSA_OUT_BYTES 6
`define CSA_CALC_LATENCY 6 // start cycle to first done cycle

`define CSA_ADDR_CHANNEL 0
`define CSA_ADDR_IN_VALID 1
`define CSA_ADDR_OUT_VALID 2
`define CSA_ADDR_IN_BYTE0 3 // input bytes 3..7
`define CSA_ADDR_OUT_WORD0 8 // result words 8..10

`define CSA_BAD_ADDR_TAG 16'hE000

`endif

// ==== logic/csa_pkg.sv ====
`include "csa_settings.svh"

package csa_pkg;

	typedef logic [`CSA_DATA_WIDTH-1:0] csa_word_t;
	typedef logic [`CSA_ADDR_BITS-1:0] csa_addr_t;
	typedef logic [8*`CSA_IN_BYTES-1:0] csa_sample_t; // byte k at [8k+7:8k]
	typedef logic [8*`CSA_OUT_BYTES-1:0] csa_result_t; // {idx, min, max, xor, sum}
	typedef logic [2:0] csa_unit_idx_t;

	typedef struct packed {
		logic en;
		csa_addr_t addr;
		logic [`CSA_DATA_WIDTH/8-1:0] strb;
		csa_word_t data;
	} csa_host_wr_t;

	typedef struct packed {
		logic start;
		csa_unit_idx_t unit;
		csa_sample_t sample;
	} csa_dispatch_t;

	typedef struct packed {
		logic clear;
		logic take_in;
		logic take_out;
	} csa_capture_t;

	typedef enum logic [1:0] {FETCH_IDLE, FETCH_TAKE, FETCH_WAIT_UNIT} csa_fetch_state_t;
	typedef enum logic [1:0] {TRACK_HOLD, TRACK_WAIT_IN, TRACK_WAIT_OUT} csa_track_state_t;
	typedef enum logic [1:0] {UNIT_IDLE, UNIT_SCAN, UNIT_DONE} csa_unit_state_t;

endpackage

// ==== logic/csa_reg_file.sv ====
`timescale 1ns/10ps
`include "csa_settings.svh"

module csa_reg_file (
	input logic axi_mm_clk,
	input logic rst_n,
	input csa_pkg::csa_host_wr_t host_wr,
	input logic ren,
	input csa_pkg::csa_addr_t raddr,
	input csa_pkg::csa_capture_t capture,
	input csa_pkg::csa_dispatch_t dispatch,
	input csa_pkg::csa_result_t collected_result,
	input logic in_valid,
	input logic out_valid,
	output csa_pkg::csa_word_t rdata,
	output csa_pkg::csa_unit_idx_t channel,
	output logic channel_changed
);
	import csa_pkg::*;

	logic wr_en_q;
	csa_addr_t wr_addr_q;
	csa_word_t wr_data_q;

	csa_sample_t in_snap;
	csa_result_t out_snap;

	csa_addr_t in_sel;
	csa_addr_t out_sel;
	csa_word_t rd_word;

	// first stage, merge enabled byte lanes into the held word
	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			wr_en_q <= 1'b0;
			wr_addr_q <= '0;
			wr_data_q <= '0;
		end else begin
			wr_en_q <= host_wr.en;
			if (host_wr.en) begin
				wr_addr_q <= host_wr.addr;
				for (int b = 0; b < `CSA_DATA_WIDTH / 8; b++) begin
					if (host_wr.strb[b])
						wr_data_q[8*b +: 8] <= host_wr.data[8*b +: 8];
				end
			end
		end
	end

	// second stage, out of range channel values are dropped
	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			channel <= '0;
			channel_changed <= 1'b0;
		end else begin
			channel_changed <= 1'b0;
			if (wr_en_q && wr_addr_q == csa_addr_t'(`CSA_ADDR_CHANNEL) &&
					wr_data_q < `CSA_UNIT_NUM) begin
				channel <= csa_unit_idx_t'(wr_data_q);
				channel_changed <= 1'b1;
			end
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (capture.clear) begin
			in_snap <= '0;
			out_snap <= '0;
		end else begin
			if (capture.take_in)
				in_snap <= dispatch.sample;
			if (capture.take_out)
				out_snap <= collected_result;
		end
	end

	assign in_sel = raddr - csa_addr_t'(`CSA_ADDR_IN_BYTE0);
	assign out_sel = raddr - csa_addr_t'(`CSA_ADDR_OUT_WORD0);

	always_comb begin
		case (raddr) inside
			`CSA_ADDR_CHANNEL: rd_word = csa_word_t'(channel);
			`CSA_ADDR_IN_VALID: rd_word = csa_word_t'(in_valid);
			`CSA_ADDR_OUT_VALID: rd_word = csa_word_t'(out_valid);
			[`CSA_ADDR_IN_BYTE0 : `CSA_ADDR_IN_BYTE0 + `CSA_IN_BYTES - 1]:
				rd_word = csa_word_t'(in_snap[8*in_sel +: 8]);
			[`CSA_ADDR_OUT_WORD0 : `CSA_ADDR_OUT_WORD0 + `CSA_OUT_BYTES / 2 - 1]:
				rd_word = csa_word_t'(out_snap[16*out_sel +: 16]); // byte pair, low byte first
			default: rd_word = {`CSA_BAD_ADDR_TAG, 16'(raddr)};
		endcase
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n)
			rdata <= '0;
		else if (ren)
			rdata <= rd_word;
	end

endmodule

// ==== logic/csa_sequencer.sv ====
`timescale 1ns/10ps
`include "csa_settings.svh"

module csa_sequencer (
	input logic axi_mm_clk,
	input logic rst_n,
	input logic csa_in_r_ready,
	input csa_pkg::csa_sample_t csa_in_rdata,
	input logic [`CSA_UNIT_NUM-1:0] busy,
	input csa_pkg::csa_unit_idx_t channel,
	input logic channel_changed,
	input logic collected,
	input csa_pkg::csa_unit_idx_t collected_unit,
	output logic csa_in_ren,
	output csa_pkg::csa_dispatch_t dispatch,
	output csa_pkg::csa_capture_t capture,
	output logic in_valid,
	output logic out_valid
);
	import csa_pkg::*;

	csa_fetch_state_t fetch_state;
	csa_track_state_t track_state;
	csa_unit_idx_t rr_idx;
	csa_unit_idx_t rr_next;

	assign rr_next = (rr_idx == csa_unit_idx_t'(`CSA_UNIT_NUM - 1)) ? '0 : rr_idx + 1'b1;

	// FETCH_TAKE spans the ren cycle and the data cycle after it
	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			fetch_state <= FETCH_IDLE;
			rr_idx <= '0;
			csa_in_ren <= 1'b0;
		end else begin
			csa_in_ren <= 1'b0;
			case (fetch_state)
				FETCH_IDLE: begin
					if (csa_in_r_ready) begin
						if (busy[rr_idx]) begin
							fetch_state <= FETCH_WAIT_UNIT; // hold off the read
						end else begin
							csa_in_ren <= 1'b1;
							fetch_state <= FETCH_TAKE;
						end
					end
				end
				FETCH_TAKE: begin
					if (!csa_in_ren) begin
						rr_idx <= rr_next;
						fetch_state <= FETCH_IDLE;
					end
				end
				FETCH_WAIT_UNIT: begin
					if (!busy[rr_idx])
						fetch_state <= FETCH_IDLE;
				end
				default: fetch_state <= FETCH_IDLE;
			endcase
		end
	end

	always_comb begin
		dispatch.start = (fetch_state == FETCH_TAKE) && !csa_in_ren;
		dispatch.unit = rr_idx;
		dispatch.sample = csa_in_rdata; // upstream data is valid the cycle after ren
	end

	always_comb begin
		capture.clear = channel_changed;
		capture.take_in = !channel_changed && track_state == TRACK_WAIT_IN &&
			dispatch.start && dispatch.unit == channel;
		capture.take_out = !channel_changed && track_state == TRACK_WAIT_OUT &&
			collected && collected_unit == channel;
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			track_state <= TRACK_WAIT_IN;
			in_valid <= 1'b0;
			out_valid <= 1'b0;
		end else if (channel_changed) begin
			track_state <= TRACK_WAIT_IN;
			in_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			case (track_state)
				TRACK_WAIT_IN: begin
					if (capture.take_in) begin
						in_valid <= 1'b1;
						track_state <= TRACK_WAIT_OUT;
					end
				end
				TRACK_WAIT_OUT: begin
					// the tracked unit stays busy until this collection
					if (capture.take_out) begin
						out_valid <= 1'b1;
						track_state <= TRACK_HOLD;
					end
				end
				TRACK_HOLD: ; // frozen until the next channel write
				default: track_state <= TRACK_WAIT_IN;
			endcase
		end
	end

endmodule

// ==== logic/csa_calc_unit.sv ====
`timescale 1ns/10ps
`include "csa_settings.svh"

module csa_calc_unit #(
	parameter int UNIT_ID = 0
) (
	input logic axi_mm_clk,
	input logic rst_n,
	input csa_pkg::csa_dispatch_t dispatch,
	input logic ack,
	output logic busy,
	output logic done,
	output csa_pkg::csa_result_t result
);
	import csa_pkg::*;

	localparam int SCAN_LAST = `CSA_CALC_LATENCY - 2;
	localparam int CNT_W = $clog2(`CSA_CALC_LATENCY);

	csa_unit_state_t state;
	logic [CNT_W-1:0] cnt;
	logic start_me;

	csa_sample_t shift_q;
	logic [15:0] sum_q;
	logic [7:0] xor_q;
	logic [7:0] max_q;
	logic [7:0] min_q;
	logic [7:0] cur_byte;

	assign start_me = dispatch.start && dispatch.unit == csa_unit_idx_t'(UNIT_ID);
	assign cur_byte = shift_q[7:0];

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			state <= UNIT_IDLE;
			cnt <= '0;
		end else begin
			case (state)
				UNIT_IDLE: begin
					if (start_me) begin
						state <= UNIT_SCAN;
						cnt <= '0;
					end
				end
				UNIT_SCAN: begin
					if (cnt == CNT_W'(SCAN_LAST))
						state <= UNIT_DONE;
					else
						cnt <= cnt + 1'b1;
				end
				UNIT_DONE: if (ack) state <= UNIT_IDLE;
				default: state <= UNIT_IDLE;
			endcase
		end
	end

	// one byte per scan cycle, lowest byte first
	always_ff @(posedge axi_mm_clk) begin
		if (state == UNIT_IDLE && start_me) begin
			shift_q <= dispatch.sample;
			sum_q <= '0;
			xor_q <= '0;
			max_q <= 8'h00;
			min_q <= 8'hff;
		end else if (state == UNIT_SCAN && cnt < `CSA_IN_BYTES) begin
			shift_q <= shift_q >> 8;
			sum_q <= sum_q + 16'(cur_byte);
			xor_q <= xor_q ^ cur_byte;
			if (cur_byte > max_q)
				max_q <= cur_byte;
			if (cur_byte < min_q)
				min_q <= cur_byte;
		end
	end

	assign busy = (state != UNIT_IDLE);
	assign done = (state == UNIT_DONE);
	assign result = {8'(UNIT_ID), min_q, max_q, xor_q, sum_q};

endmodule

// ==== logic/csa_result_collector.sv ====
`timescale 1ns/10ps
`include "csa_settings.svh"

module csa_result_collector (
	input logic axi_mm_clk,
	input logic rst_n,
	input logic [`CSA_UNIT_NUM-1:0] done,
	input csa_pkg::csa_result_t results [`CSA_UNIT_NUM],
	output logic [`CSA_UNIT_NUM-1:0] ack,
	output logic collected,
	output csa_pkg::csa_unit_idx_t collected_unit,
	output csa_pkg::csa_result_t collected_result,
	output logic csa_out_wen,
	output csa_pkg::csa_result_t csa_out_wdata
);
	import csa_pkg::*;

	logic [`CSA_UNIT_NUM-1:0] ready_units;
	logic pick_valid;
	csa_unit_idx_t pick;

	assign ready_units = done & ~ack; // acked unit still shows done for one cycle

	always_comb begin
		pick_valid = 1'b0;
		pick = '0;
		for (int i = `CSA_UNIT_NUM - 1; i >= 0; i--) begin
			if (ready_units[i]) begin
				pick_valid = 1'b1;
				pick = csa_unit_idx_t'(i);
			end
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			ack <= '0;
			csa_out_wen <= 1'b0;
		end else begin
			ack <= '0;
			ack[pick] <= pick_valid;
			csa_out_wen <= pick_valid;
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (pick_valid) begin
			csa_out_wdata <= results[pick];
			collected_unit <= pick;
		end
	end

	assign collected = csa_out_wen;
	assign collected_result = csa_out_wdata;

endmodule

// ==== logic/csa_subsystem.sv ====
`timescale 1ns/10ps
`include "csa_settings.svh"

module csa_subsystem (
	input logic axi_mm_clk,
	input logic rst_n,
	input logic wen,
	input logic [`CSA_DATA_WIDTH/8-1:0] wstrb,
	input csa_pkg::csa_addr_t waddr,
	input csa_pkg::csa_word_t wdata,
	input logic ren,
	input csa_pkg::csa_addr_t raddr,
	output csa_pkg::csa_word_t rdata,
	input logic csa_in_r_ready,
	output logic csa_in_ren,
	input csa_pkg::csa_sample_t csa_in_rdata,
	output logic csa_out_wen,
	output csa_pkg::csa_result_t csa_out_wdata
);
	import csa_pkg::*;

	csa_host_wr_t host_wr;
	csa_unit_idx_t channel;
	logic channel_changed;
	csa_capture_t capture;
	csa_dispatch_t dispatch;
	logic in_valid;
	logic out_valid;

	logic [`CSA_UNIT_NUM-1:0] busy;
	logic [`CSA_UNIT_NUM-1:0] done;
	logic [`CSA_UNIT_NUM-1:0] ack;
	csa_result_t results [`CSA_UNIT_NUM];

	logic collected;
	csa_unit_idx_t collected_unit;
	csa_result_t collected_result;

	assign host_wr = '{en: wen, addr: waddr, strb: wstrb, data: wdata};

	csa_reg_file u_reg_file (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.host_wr(host_wr),
		.ren(ren),
		.raddr(raddr),
		.capture(capture),
		.dispatch(dispatch),
		.collected_result(collected_result),
		.in_valid(in_valid),
		.out_valid(out_valid),
		.rdata(rdata),
		.channel(channel),
		.channel_changed(channel_changed)
	);

	csa_sequencer u_sequencer (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.csa_in_r_ready(csa_in_r_ready),
		.csa_in_rdata(csa_in_rdata),
		.busy(busy),
		.channel(channel),
		.channel_changed(channel_changed),
		.collected(collected),
		.collected_unit(collected_unit),
		.csa_in_ren(csa_in_ren),
		.dispatch(dispatch),
		.capture(capture),
		.in_valid(in_valid),
		.out_valid(out_valid)
	);

	// all units see the same dispatch and decode their own index
	for (genvar i = 0; i < `CSA_UNIT_NUM; i++) begin : g_unit
		csa_calc_unit #(.UNIT_ID(i)) u_unit (
			.axi_mm_clk(axi_mm_clk),
			.rst_n(rst_n),
			.dispatch(dispatch),
			.ack(ack[i]),
			.busy(busy[i]),
			.done(done[i]),
			.result(results[i])
		);
	end

	csa_result_collector u_collector (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.done(done),
		.results(results),
		.ack(ack),
		.collected(collected),
		.collected_unit(collected_unit),
		.collected_result(collected_result),
		.csa_out_wen(csa_out_wen),
		.csa_out_wdata(csa_out_wdata)
	);

endmodule

// ==== testbench/csa_subsystem_checker.sv ====
`timescale 1ns/10ps
`include "csa_settings.svh"

module csa_subsystem_checker (
	input logic axi_mm_clk,
	input logic rst_n,
	input logic csa_in_ren,
	input logic csa_out_wen,
	input csa_pkg::csa_unit_idx_t channel,
	input logic in_valid,
	input logic out_valid
);
	int unsigned fail_count = 0; // picked up by the testbench at the end

	ren_single: assert property (@(posedge axi_mm_clk) disable iff (!rst_n)
		csa_in_ren |=> !csa_in_ren)
	else begin
		fail_count++;
		$error("csa_in_ren stayed high for more than one cycle");
	end

	wen_single: assert property (@(posedge axi_mm_clk) disable iff (!rst_n)
		csa_out_wen |=> !csa_out_wen)
	else begin
		fail_count++;
		$error("csa_out_wen stayed high for more than one cycle");
	end

	channel_range: assert property (@(posedge axi_mm_clk) disable iff (!rst_n)
		channel < `CSA_UNIT_NUM)
	else begin
		fail_count++;
		$error("channel register out of range");
	end

	// result snapshot never ahead of its sample
	valid_order: assert property (@(posedge axi_mm_clk) disable iff (!rst_n)
		out_valid |-> in_valid)
	else begin
		fail_count++;
		$error("out_valid set while in_valid is low");
	end

endmodule

bind csa_subsystem csa_subsystem_checker u_checker (
	.axi_mm_clk(axi_mm_clk),
	.rst_n(rst_n),
	.csa_in_ren(csa_in_ren),
	.csa_out_wen(csa_out_wen),
	.channel(channel),
	.in_valid(in_valid),
	.out_valid(out_valid)
);

// ==== testbench/tb_csa_subsystem.sv ====
`timescale 1ns/10ps
`include "csa_settings.svh"

module tb_csa_subsystem;
	import csa_pkg::*;

	localparam int SEED = 61171;

	logic axi_mm_clk;
	logic rst_n;
	logic wen;
	logic [3:0] wstrb;
	csa_addr_t waddr;
	csa_word_t wdata;
	logic ren;
	csa_addr_t raddr;
	csa_word_t rdata;
	logic csa_in_r_ready = 1'b0;
	logic csa_in_ren;
	csa_sample_t csa_in_rdata = '0;
	logic csa_out_wen;
	csa_result_t csa_out_wdata;

	csa_sample_t up_q[$]; // samples waiting in the upstream buffer
	csa_sample_t exp_samples[$];
	csa_unit_idx_t exp_units[$];
	csa_unit_idx_t next_unit = '0;

	int in_count = 0;
	int wen_count = 0;
	int main_errs = 0;
	int up_errs = 0;
	int cmp_errs = 0;
	int main_checks = 0;
	int cmp_checks = 0;

	csa_word_t wr_hold = '0; // model of the captured write word
	csa_unit_idx_t exp_channel = '0;
	logic track_armed = 1'b0;
	csa_unit_idx_t track_ch = '0;
	csa_sample_t track_sample = '0;

	csa_subsystem u_dut (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.wen(wen),
		.wstrb(wstrb),
		.waddr(waddr),
		.wdata(wdata),
		.ren(ren),
		.raddr(raddr),
		.rdata(rdata),
		.csa_in_r_ready(csa_in_r_ready),
		.csa_in_ren(csa_in_ren),
		.csa_in_rdata(csa_in_rdata),
		.csa_out_wen(csa_out_wen),
		.csa_out_wdata(csa_out_wdata)
	);

	initial begin
		axi_mm_clk = 1'b0;
		forever #10 axi_mm_clk = ~axi_mm_clk;
	end

	function automatic csa_result_t csa_expected(input csa_sample_t sample,
			input csa_unit_idx_t unit);
		logic [15:0] sum;
		logic [7:0] x;
		logic [7:0] mx;
		logic [7:0] mn;
		logic [7:0] b;
		sum = '0;
		x = '0;
		mx = 8'h00;
		mn = 8'hff;
		for (int k = 0; k < `CSA_IN_BYTES; k++) begin
			b = sample[8*k +: 8];
			sum = sum + 16'(b);
			x = x ^ b;
			if (b > mx)
				mx = b;
			if (b < mn)
				mn = b;
		end
		return {8'(unit), mn, mx, x, sum};
	endfunction

	// upstream buffer, data shows up the cycle after a read pulse
	always @(negedge axi_mm_clk) begin
		if (csa_in_ren) begin
			in_count++; // every read pulse, even one on an empty buffer
			if (up_q.size() == 0) begin
				$display("upstream read while the source buffer was empty");
				up_errs++;
			end else begin
				csa_in_rdata = up_q.pop_front();
				exp_samples.push_back(csa_in_rdata);
				exp_units.push_back(next_unit);
				if (track_armed && next_unit == track_ch) begin
					track_sample = csa_in_rdata;
					track_armed = 1'b0;
				end
				next_unit = (next_unit == csa_unit_idx_t'(`CSA_UNIT_NUM - 1)) ?
					'0 : next_unit + 3'd1;
			end
		end
		csa_in_r_ready = (up_q.size() != 0) && (($urandom % 4) != 0); // random gaps
	end

	always @(negedge axi_mm_clk) begin : compare_out
		csa_sample_t s;
		csa_unit_idx_t u;
		csa_result_t exp;
		if (csa_out_wen) begin
			wen_count++;
			if (exp_samples.size() == 0) begin
				$display("output write with no sample outstanding");
				cmp_errs++;
			end else begin
				s = exp_samples.pop_front();
				u = exp_units.pop_front();
				exp = csa_expected(s, u);
				cmp_checks++;
				if (csa_out_wdata !== exp) begin
					$display("ERROR csa_out_wdata: got %h expected %h", csa_out_wdata, exp);
					cmp_errs++;
				end
			end
		end
	end

	function automatic int total_errors();
		return main_errs + up_errs + cmp_errs + int'(u_dut.u_checker.fail_count);
	endfunction

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		main_errs++;
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		main_checks++;
		if (got !== exp) begin
			$display("ERROR %s: got %h expected %h", name, got, exp);
			main_errs++;
		end
	endtask

	task automatic host_write(input csa_addr_t addr, input logic [3:0] strb,
			input csa_word_t data);
		@(negedge axi_mm_clk);
		wen = 1'b1;
		waddr = addr;
		wstrb = strb;
		wdata = data;
		@(negedge axi_mm_clk);
		wen = 1'b0;
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				wr_hold[8*b +: 8] = data[8*b +: 8];
		end
		if (addr == csa_addr_t'(`CSA_ADDR_CHANNEL) && wr_hold < `CSA_UNIT_NUM)
			exp_channel = csa_unit_idx_t'(wr_hold);
		repeat (2) @(negedge axi_mm_clk); // channel and tracking reset settle
	endtask

	task automatic check_reg(input int addr, input csa_word_t exp, input string name);
		csa_word_t got;
		@(negedge axi_mm_clk);
		ren = 1'b1;
		raddr = csa_addr_t'(addr);
		@(negedge axi_mm_clk);
		ren = 1'b0;
		got = rdata;
		check_value(name, 64'(got), 64'(exp));
	endtask

	task automatic send_samples(input int n);
		for (int i = 0; i < n; i++)
			up_q.push_back(csa_sample_t'({$urandom, $urandom}));
	endtask

	task automatic wait_stream_idle(input int limit);
		int cycles;
		cycles = 0;
		while (!(up_q.size() == 0 && exp_samples.size() == 0) && cycles < limit) begin
			@(negedge axi_mm_clk);
			cycles++;
		end
		if (!(up_q.size() == 0 && exp_samples.size() == 0))
			report_timeout("the sample stream to drain");
	endtask

	task automatic report_test(input int num, input string name, input int errs_before);
		int errs;
		errs = total_errors() - errs_before;
		if (errs == 0)
			$display("test %0d %s: ok", num, name);
		else
			$display("test %0d %s: %0d errors", num, name, errs);
	endtask

	initial begin
		int base;
		int in0;
		int wen0;
		csa_result_t exp_res;
		void'($urandom(SEED));
		rst_n = 1'b0;
		wen = 1'b0;
		wstrb = '0;
		waddr = '0;
		wdata = '0;
		ren = 1'b0;
		raddr = '0;
		repeat (10) @(posedge axi_mm_clk);
		@(negedge axi_mm_clk);
		rst_n = 1'b1;

		base = total_errors();
		check_reg(`CSA_ADDR_CHANNEL, 32'd0, "rdata channel");
		check_reg(`CSA_ADDR_IN_VALID, 32'd0, "rdata in_valid");
		check_reg(`CSA_ADDR_OUT_VALID, 32'd0, "rdata out_valid");
		repeat (20) @(negedge axi_mm_clk); // ready stays low, nothing may move
		check_value("csa_in_ren pulses", 64'(in_count), 64'd0);
		check_value("csa_out_wen pulses", 64'(wen_count), 64'd0);
		report_test(1, "reset and stall", base);

		base = total_errors();
		host_write(`CSA_ADDR_CHANNEL, 4'hf, 32'd3);
		check_reg(`CSA_ADDR_CHANNEL, 32'(exp_channel), "rdata channel after 3");
		host_write(`CSA_ADDR_CHANNEL, 4'hf, 32'd7);
		check_reg(`CSA_ADDR_CHANNEL, 32'(exp_channel), "rdata channel after 7");
		host_write(`CSA_ADDR_CHANNEL, 4'hf, 32'h0000_0102);
		check_reg(`CSA_ADDR_CHANNEL, 32'(exp_channel), "rdata channel after 0x102");
		host_write(`CSA_ADDR_CHANNEL, 4'b0010, 32'haabb_00cc); // lane 1 clears the 0x100
		check_reg(`CSA_ADDR_CHANNEL, 32'(exp_channel), "rdata channel after lane 1");
		report_test(2, "channel register", base);

		base = total_errors();
		in0 = in_count;
		wen0 = wen_count;
		send_samples(40);
		wait_stream_idle(5000);
		check_value("csa_in_ren pulses", 64'(in_count - in0), 64'd40);
		check_value("csa_out_wen pulses", 64'(wen_count - wen0), 64'(in_count - in0));
		report_test(3, "random stream", base);

		base = total_errors();
		track_ch = csa_unit_idx_t'($urandom % `CSA_UNIT_NUM);
		host_write(`CSA_ADDR_CHANNEL, 4'hf, 32'(track_ch));
		track_armed = 1'b1;
		send_samples(7);
		wait_stream_idle(2000);
		if (track_armed) begin
			$display("no sample was dispatched to the watched channel");
			main_errs++;
		end
		check_reg(`CSA_ADDR_IN_VALID, 32'd1, "rdata in_valid");
		check_reg(`CSA_ADDR_OUT_VALID, 32'd1, "rdata out_valid");
		for (int k = 0; k < `CSA_IN_BYTES; k++)
			check_reg(`CSA_ADDR_IN_BYTE0 + k, 32'(track_sample[8*k +: 8]),
				$sformatf("rdata input byte %0d", k));
		exp_res = csa_expected(track_sample, track_ch);
		for (int w = 0; w < `CSA_OUT_BYTES / 2; w++)
			check_reg(`CSA_ADDR_OUT_WORD0 + w, 32'(exp_res[16*w +: 16]),
				$sformatf("rdata result word %0d", w));
		report_test(4, "channel snapshot", base);

		base = total_errors();
		for (int a = `CSA_ADDR_OUT_WORD0 + `CSA_OUT_BYTES / 2; a < 32; a++)
			check_reg(a, {`CSA_BAD_ADDR_TAG, 16'(a)}, $sformatf("rdata at %0d", a));
		report_test(5, "unmapped reads", base);

		$display("checks %0d errors %0d", main_checks + cmp_checks, total_errors());
		if (total_errors() == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== csa_subsystem.f ====
+incdir+include
logic/csa_pkg.sv
logic/csa_reg_file.sv
logic/csa_sequencer.sv
logic/csa_calc_unit.sv
logic/csa_result_collector.sv
logic/csa_subsystem.sv
testbench/csa_subsystem_checker.sv
testbench/tb_csa_subsystem.sv

// ==== Makefile ====
TOP := tb_csa_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f csa_subsystem.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1
	cat sim.log
	@if grep -q "Checks failed" sim.log; then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@echo "simulation finished without failures"

clean:
	rm -rf obj_dir sim.log
